/* rp_bus_pkg.sv */
// ------------------------------------------------
// system bus map: 8 regions of 1 MB, picked by addr[22:20]
// only the peak detector region is populated here
// ------------------------------------------------
package rp_bus_pkg;

  // bus widths
  localparam int BUS_DATA_W = 32;
  localparam int BUS_ADDR_W = 32;

  // region field inside the address
  localparam int REGION_MSB = 22;
  localparam int REGION_LSB = 20;
  localparam int REGION_N   = 8;     // must match msb-lsb+1 bits

  localparam int PD_REGION  = 6;     // peak detector slave

  // ------------------------------------------------
  // bus words
  // ------------------------------------------------
  typedef logic [BUS_DATA_W-1:0] bus_word_t;
  typedef logic [BUS_ADDR_W-1:0] bus_addr_t;

endpackage

/* rp_adc_pkg.sv */
// ------------------------------------------------
// sample format after conversion is two's complement
// peak offsets are byte offsets inside region 6, low 8 bits only
// ------------------------------------------------
package rp_adc_pkg;

  // converted ADC sample
  localparam int SAMPLE_W = 14;
  typedef logic signed [SAMPLE_W-1:0] adc_sample_t;

  // magnitude drops the sign bit
  localparam int MAG_W = 13;
  typedef logic [MAG_W-1:0] peak_mag_t;

  // peak detector register offsets
  localparam int PD_OFS_W = 8;
  localparam logic [PD_OFS_W-1:0] PD_CTRL_OFS = 8'h00;  // start, chan, busy, done
  localparam logic [PD_OFS_W-1:0] PD_LEN_OFS  = 8'h04;  // window length
  localparam logic [PD_OFS_W-1:0] PD_AMPL_OFS = 8'h08;  // peak amplitude, ro
  localparam logic [PD_OFS_W-1:0] PD_LOC_OFS  = 8'h0C;  // peak location, ro

endpackage

/* sys_bus_if.sv */
// ------------------------------------------------
// one decoded bus region, strobes are one-cycle pulses
// ------------------------------------------------
`timescale 1ns/1ps

interface sys_bus_if import rp_bus_pkg::*; ();

  bus_addr_t addr;    // full address, region already decoded
  bus_word_t wdata;
  logic      wen;     // write strobe
  logic      ren;     // read strobe
  bus_word_t rdata;   // valid with ack only
  logic      ack;
  logic      err;

  // decoder side
  modport master (
    output addr, wdata, wen, ren,
    input  rdata, ack, err
  );

  // register block side
  modport slave (
    input  addr, wdata, wen, ren,
    output rdata, ack, err
  );

endinterface

/* sys_bus_decoder.sv */
// ------------------------------------------------
// answers exactly one cycle after each strobe, no back-pressure
// ------------------------------------------------
`timescale 1ns/1ps

module sys_bus_decoder import rp_bus_pkg::*; (
  input  logic      adc_clk,
  input  logic      reset_i,
  input  bus_addr_t sys_addr_i,
  input  bus_word_t sys_wdata_i,
  input  logic      sys_wen_i,
  input  logic      sys_ren_i,
  output bus_word_t sys_rdata_o,
  output logic      sys_ack_o,
  output logic      sys_err_o,
  sys_bus_if.master pd_bus_o
);

  logic [$clog2(REGION_N)-1:0] region;
  logic                        pd_hit;
  logic                        pd_sel_q;    // last request went to region 6
  logic                        miss_ack_q;  // local ack+err for empty regions

  // region decode
  assign region = sys_addr_i[REGION_MSB:REGION_LSB];
  assign pd_hit = (int'(region) == PD_REGION);

  // forward to slave, strobes only on match
  assign pd_bus_o.addr  = sys_addr_i;
  assign pd_bus_o.wdata = sys_wdata_i;
  assign pd_bus_o.wen   = sys_wen_i & pd_hit;
  assign pd_bus_o.ren   = sys_ren_i & pd_hit;

  // ------------------------------------------------
  // error responder and answer select
  // ------------------------------------------------
  always_ff @(posedge adc_clk) begin
    if (reset_i) begin
      pd_sel_q   <= 1'b0;
      miss_ack_q <= 1'b0;
    end else begin
      pd_sel_q   <= pd_hit;
      miss_ack_q <= (sys_wen_i | sys_ren_i) & ~pd_hit;
    end
  end

  // slave keeps rdata at zero outside ack
  assign sys_ack_o   = pd_sel_q ? pd_bus_o.ack : miss_ack_q;
  assign sys_err_o   = pd_sel_q ? pd_bus_o.err : miss_ack_q;
  assign sys_rdata_o = pd_sel_q ? pd_bus_o.rdata : '0;

  // whichever region is hit, the answer comes next cycle
  a_ack_next: assert property (@(posedge adc_clk) disable iff (reset_i)
    (sys_wen_i || sys_ren_i) |=> sys_ack_o);

endmodule

/* adc_frontend.sv */
// ------------------------------------------------
// raw ADC words are unsigned with negative slope, 1 cycle latency
// ------------------------------------------------
`timescale 1ns/1ps

module adc_frontend import rp_adc_pkg::*; (
  input  logic                adc_clk,
  input  logic                reset_i,
  input  logic [SAMPLE_W-1:0] adc_dat_a_i,  // raw ch A
  input  logic [SAMPLE_W-1:0] adc_dat_b_i,  // raw ch B
  output adc_sample_t         adc_a_o,
  output adc_sample_t         adc_b_o
);

  adc_sample_t adc_a_q;
  adc_sample_t adc_b_q;

  // keep msb, flip the rest -> two's complement
  always_ff @(posedge adc_clk) begin
    if (reset_i) begin
      adc_a_q <= '0;
      adc_b_q <= '0;
    end else begin
      adc_a_q <= {adc_dat_a_i[SAMPLE_W-1], ~adc_dat_a_i[SAMPLE_W-2:0]};
      adc_b_q <= {adc_dat_b_i[SAMPLE_W-1], ~adc_dat_b_i[SAMPLE_W-2:0]};
    end
  end

  assign adc_a_o = adc_a_q;
  assign adc_b_o = adc_b_q;

endmodule

/* pd_ctrl_fsm.sv */
// ------------------------------------------------
// start is ignored while running; length 0 jumps to done
// ------------------------------------------------
`timescale 1ns/1ps

module pd_ctrl_fsm #(
  parameter int PD_CNT_W = 16
) (
  input  logic                adc_clk,
  input  logic                reset_i,
  input  logic                start_i,
  input  logic                last_i,
  input  logic [PD_CNT_W-1:0] win_len_i,
  output logic                run_o,
  output logic                clear_o,
  output logic                busy_o,
  output logic                done_o
);

  typedef enum logic [1:0] {ST_IDLE, ST_RUN, ST_DONE} state_t;

  state_t state_q;
  logic   clear_q;   // one cycle after an accepted start

  always_ff @(posedge adc_clk) begin
    if (reset_i) begin
      state_q <= ST_IDLE;
      clear_q <= 1'b0;
    end else begin
      clear_q <= 1'b0;
      case (state_q)
        ST_IDLE, ST_DONE: begin
          if (start_i) begin
            clear_q <= 1'b1;                     // wipe counter and peak
            state_q <= (win_len_i == '0) ? ST_DONE : ST_RUN;
          end
        end
        ST_RUN:  if (last_i) state_q <= ST_DONE; // last sample taken
        default: state_q <= ST_IDLE;
      endcase
    end
  end

  assign run_o   = (state_q == ST_RUN);
  assign busy_o  = (state_q == ST_RUN);
  assign done_o  = (state_q == ST_DONE);
  assign clear_o = clear_q;

  // counter's last pulse falls inside a running window
  a_last_in_run: assert property (@(posedge adc_clk) disable iff (reset_i)
    last_i |-> (busy_o && !clear_o));
  a_busy_done_excl: assert property (@(posedge adc_clk) disable iff (reset_i)
    !(busy_o && done_o));

endmodule

/* pd_window_counter.sv */
// ------------------------------------------------
// index holds at L-1; last is registered, one cycle after L-1
// ------------------------------------------------
`timescale 1ns/1ps

module pd_window_counter #(
  parameter int PD_CNT_W = 16
) (
  input  logic                adc_clk,
  input  logic                reset_i,
  input  logic                run_i,
  input  logic                clear_i,
  input  logic [PD_CNT_W-1:0] win_len_i,
  output logic [PD_CNT_W-1:0] idx_o,
  output logic                last_o
);

  logic [PD_CNT_W-1:0] idx_q;
  logic [PD_CNT_W-1:0] idx_max;
  logic                at_end;
  logic                last_q;

  assign idx_max = win_len_i - 1'b1;
  assign at_end  = (idx_q == idx_max);

  always_ff @(posedge adc_clk) begin
    if (reset_i || clear_i) begin
      idx_q  <= '0;
      last_q <= 1'b0;
    end else begin
      last_q <= run_i & at_end & ~last_q;     // single pulse
      if (run_i && !at_end) idx_q <= idx_q + 1'b1;
    end
  end

  assign idx_o  = idx_q;
  assign last_o = last_q;

  // length stays frozen by the register block during a window
  a_idx_in_win: assert property (@(posedge adc_clk) disable iff (reset_i)
    (run_i && !clear_i) |-> (idx_o < win_len_i));

endmodule

/* pd_peak_tracker.sv */
// ------------------------------------------------
// magnitude is the reference one's-complement rule, ties go to later sample
// ------------------------------------------------
`timescale 1ns/1ps

module pd_peak_tracker import rp_adc_pkg::*; #(
  parameter int PD_CNT_W = 16
) (
  input  logic                adc_clk,
  input  logic                reset_i,
  input  logic                run_i,
  input  logic                clear_i,
  input  logic                last_i,
  input  logic                chan_sel_i,  // 0 = A, 1 = B
  input  adc_sample_t         adc_a_i,
  input  adc_sample_t         adc_b_i,
  input  logic [PD_CNT_W-1:0] idx_i,
  output peak_mag_t           peak_ampl_o,
  output logic [PD_CNT_W-1:0] peak_loc_o,
  output logic [7:0]          led_o
);

  adc_sample_t         sample;
  peak_mag_t           mag;
  logic                take;      // sample belongs to the window
  peak_mag_t           ampl_q;
  logic [PD_CNT_W-1:0] loc_q;

  assign sample = chan_sel_i ? adc_b_i : adc_a_i;
  assign mag    = sample[SAMPLE_W-1] ? ~sample[MAG_W-1:0] : sample[MAG_W-1:0];
  assign take   = run_i & ~last_i;

  // ------------------------------------------------
  // peak hold
  // ------------------------------------------------
  always_ff @(posedge adc_clk) begin
    if (reset_i || clear_i) begin
      ampl_q <= '0;
      loc_q  <= '0;
    end else if (take && (mag >= ampl_q)) begin  // >= moves ties later
      ampl_q <= mag;
      loc_q  <= idx_i;
    end
  end

  assign peak_ampl_o = ampl_q;
  assign peak_loc_o  = loc_q;

  // top 7 magnitude bits plus live sign
  assign led_o = {sample[SAMPLE_W-1], ampl_q[MAG_W-1 -: 7]};

endmodule

/* pd_regs.sv */
// ------------------------------------------------
// length and channel are frozen while busy; amplitude and location are ro
// ------------------------------------------------
`timescale 1ns/1ps

module pd_regs import rp_bus_pkg::*, rp_adc_pkg::*; #(
  parameter int PD_CNT_W = 16
) (
  input  logic                adc_clk,
  input  logic                reset_i,
  input  logic                busy_i,
  input  logic                done_i,
  input  peak_mag_t           peak_ampl_i,
  input  logic [PD_CNT_W-1:0] peak_loc_i,
  sys_bus_if.slave            bus_s,
  output logic                start_o,
  output logic                chan_sel_o,
  output logic [PD_CNT_W-1:0] win_len_o
);

  logic [PD_OFS_W-1:0] ofs;
  logic                ofs_ok;     // upper offset bits clear
  logic                hit_ctrl;
  logic                hit_len;
  logic                hit_ampl;
  logic                hit_loc;
  logic                hit_any;
  logic                req;
  bus_word_t           rd_word;
  logic                chan_sel_q;
  logic [PD_CNT_W-1:0] win_len_q;
  bus_word_t           rdata_q;
  logic                ack_q;
  logic                err_q;

  // offset decode
  assign ofs      = bus_s.addr[PD_OFS_W-1:0];
  assign ofs_ok   = (bus_s.addr[REGION_LSB-1:PD_OFS_W] == '0);
  assign hit_ctrl = ofs_ok && (ofs == PD_CTRL_OFS);
  assign hit_len  = ofs_ok && (ofs == PD_LEN_OFS);
  assign hit_ampl = ofs_ok && (ofs == PD_AMPL_OFS);
  assign hit_loc  = ofs_ok && (ofs == PD_LOC_OFS);
  assign hit_any  = hit_ctrl | hit_len | hit_ampl | hit_loc;
  assign req      = bus_s.wen | bus_s.ren;

  // ctrl bit 0, fsm drops it when busy
  assign start_o = bus_s.wen & hit_ctrl & bus_s.wdata[0];

  always_ff @(posedge adc_clk) begin
    if (reset_i) begin
      chan_sel_q <= 1'b0;
      win_len_q  <= '0;
    end else if (bus_s.wen && !busy_i) begin
      if (hit_ctrl) chan_sel_q <= bus_s.wdata[1];
      if (hit_len)  win_len_q  <= bus_s.wdata[PD_CNT_W-1:0];
    end
  end

  // ------------------------------------------------
  // read back
  // ------------------------------------------------
  always_comb begin
    rd_word = '0;
    if (hit_ctrl) begin
      rd_word[1] = chan_sel_q;
      rd_word[8] = busy_i;
      rd_word[9] = done_i;
    end else if (hit_len) begin
      rd_word = BUS_DATA_W'(win_len_q);
    end else if (hit_ampl) begin
      rd_word = BUS_DATA_W'(peak_ampl_i);
    end else if (hit_loc) begin
      rd_word = BUS_DATA_W'(peak_loc_i);
    end
  end

  // answer next cycle, rdata zero outside a read ack
  always_ff @(posedge adc_clk) begin
    if (reset_i) begin
      ack_q   <= 1'b0;
      err_q   <= 1'b0;
      rdata_q <= '0;
    end else begin
      ack_q   <= req;
      err_q   <= req & ~hit_any;                      // unknown offset
      rdata_q <= (bus_s.ren && hit_any) ? rd_word : '0;
    end
  end

  assign bus_s.ack   = ack_q;
  assign bus_s.err   = err_q;
  assign bus_s.rdata = rdata_q;
  assign chan_sel_o  = chan_sel_q;
  assign win_len_o   = win_len_q;

endmodule

/* rp_top.sv */
// ------------------------------------------------
// single adc_clk domain, bus included; only region 6 is mapped
// ------------------------------------------------
`timescale 1ns/1ps

module rp_top import rp_bus_pkg::*, rp_adc_pkg::*; #(
  parameter int PD_CNT_W = 16          // window length and location width
) (
  input  logic                adc_clk,
  input  logic                reset_i,
  input  logic [SAMPLE_W-1:0] adc_dat_a_i,
  input  logic [SAMPLE_W-1:0] adc_dat_b_i,
  input  bus_addr_t           sys_addr_i,
  input  bus_word_t           sys_wdata_i,
  input  logic                sys_wen_i,
  input  logic                sys_ren_i,
  output bus_word_t           sys_rdata_o,
  output logic                sys_ack_o,
  output logic                sys_err_o,
  output logic [7:0]          led_o
);

  adc_sample_t         adc_a;
  adc_sample_t         adc_b;
  logic                start;
  logic                chan_sel;
  logic [PD_CNT_W-1:0] win_len;
  logic                run;
  logic                clear;
  logic                busy;
  logic                done;
  logic                last;
  logic [PD_CNT_W-1:0] idx;
  peak_mag_t           peak_ampl;
  logic [PD_CNT_W-1:0] peak_loc;

  sys_bus_if pd_bus ();   // region 6 link

  // ------------------------------------------------
  // bus and ADC
  // ------------------------------------------------
  sys_bus_decoder i_dec (
    .adc_clk, .reset_i,
    .sys_addr_i, .sys_wdata_i, .sys_wen_i, .sys_ren_i,
    .sys_rdata_o, .sys_ack_o, .sys_err_o,
    .pd_bus_o (pd_bus)
  );

  adc_frontend i_adc (
    .adc_clk, .reset_i, .adc_dat_a_i, .adc_dat_b_i,
    .adc_a_o (adc_a),
    .adc_b_o (adc_b)
  );

  // ------------------------------------------------
  // peak detector
  // ------------------------------------------------
  pd_regs #(.PD_CNT_W(PD_CNT_W)) i_regs (
    .adc_clk, .reset_i,
    .busy_i (busy), .done_i (done), .peak_ampl_i (peak_ampl), .peak_loc_i (peak_loc),
    .bus_s (pd_bus),
    .start_o (start), .chan_sel_o (chan_sel), .win_len_o (win_len)
  );

  pd_ctrl_fsm #(.PD_CNT_W(PD_CNT_W)) i_fsm (
    .adc_clk, .reset_i, .start_i (start), .last_i (last), .win_len_i (win_len),
    .run_o (run), .clear_o (clear), .busy_o (busy), .done_o (done)
  );

  pd_window_counter #(.PD_CNT_W(PD_CNT_W)) i_cnt (
    .adc_clk, .reset_i, .run_i (run), .clear_i (clear), .win_len_i (win_len),
    .idx_o (idx), .last_o (last)
  );

  pd_peak_tracker #(.PD_CNT_W(PD_CNT_W)) i_trk (
    .adc_clk, .reset_i, .run_i (run), .clear_i (clear), .last_i (last),
    .chan_sel_i (chan_sel), .adc_a_i (adc_a), .adc_b_i (adc_b), .idx_i (idx),
    .peak_ampl_o (peak_ampl), .peak_loc_o (peak_loc), .led_o
  );

endmodule

/* tb_rp_top.sv */
// ------------------------------------------------
// directed tests through the bus only; inputs change on the falling edge
// ------------------------------------------------
`timescale 1ns/1ps

module tb_rp_top import rp_bus_pkg::*, rp_adc_pkg::*; ();

  localparam int          CLK_PERIOD = 100;
  localparam int          RESET_CYC  = 16;
  localparam int          TEST_CYC   = 6 + 20 + (8 + 12) + (32 + 12) + (16 + 18) + 14;
  localparam int          WD_CYC     = RESET_CYC + TEST_CYC + 50;  // tests plus margin
  localparam logic [31:0] LFSR_SEED  = 32'h3101_3f72;
  localparam bus_addr_t   PD_BASE    = bus_addr_t'(PD_REGION) << REGION_LSB;
  // two equal magnitudes at 2 and 5, later one must win
  localparam logic [13:0] KNOWN_SEQ [8] = '{14'h1000, 14'h2800, 14'h0100, 14'h1FFF,
                                             14'h0800, 14'h3EFF, 14'h3000, 14'h2000};

  logic        adc_clk;
  logic        reset_i;
  logic [13:0] adc_dat_a_i;
  logic [13:0] adc_dat_b_i;
  bus_addr_t   sys_addr_i;
  bus_word_t   sys_wdata_i;
  logic        sys_wen_i;
  logic        sys_ren_i;
  bus_word_t   sys_rdata_o;
  logic        sys_ack_o;
  logic        sys_err_o;
  logic [7:0]  led_o;
  string       test_name;
  logic [31:0] lfsr_q;
  logic [13:0] win_raw [64];      // raw samples of the next window
  bus_word_t   rd_data;           // last bus answer
  logic        rd_err;

  rp_top #(.PD_CNT_W(16)) rp_top_i (.*);

  initial begin
    adc_clk = 1'b0;
    forever #(CLK_PERIOD / 2) adc_clk = ~adc_clk;
  end

  initial begin
    #(WD_CYC * CLK_PERIOD);
    $display("watchdog expired before the tests finished");
    $display("Something failed");
    $fatal(1, "timeout");
  end

  // ------------------------------------------------
  // error handling and reference model
  // ------------------------------------------------
  task automatic stop_run(input string what);
    $display("%s", what);
    $display("Something failed");
    $fatal(1, "stopped at first error");
  endtask

  task automatic check_eq(input string what, input logic [31:0] exp, input logic [31:0] act);
    assert (act === exp) else
      stop_run($sformatf("FAILED %s: %s expected 0x%0h actual 0x%0h",
                         test_name, what, exp, act));
  endtask

  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};  // x^32+x^22+x^2+x+1
  endfunction

  function automatic logic [13:0] rand_sample();
    logic [13:0] v;
    v = '0;
    for (int i = 0; i < 14; i++) begin
      lfsr_q = lfsr_step(lfsr_q);     // one step per bit
      v      = {v[12:0], lfsr_q[0]};
    end
    return v;
  endfunction

  function automatic logic [13:0] to_twos(input logic [13:0] raw);
    return {raw[13], ~raw[12:0]};
  endfunction

  function automatic logic [12:0] magnitude(input logic [13:0] s);
    return s[13] ? ~s[12:0] : s[12:0];
  endfunction

  function automatic bus_word_t ctrl_word(input logic chan, input logic busy, input logic done);
    bus_word_t w;
    w    = '0;
    w[1] = chan;
    w[8] = busy;
    w[9] = done;
    return w;
  endfunction

  function automatic bus_addr_t pd_addr(input logic [PD_OFS_W-1:0] ofs);
    return PD_BASE | bus_addr_t'(ofs);
  endfunction

  task automatic drive_raw(input logic chan, input logic [13:0] v);
    if (chan) adc_dat_b_i = v;
    else adc_dat_a_i = v;
  endtask

  // ------------------------------------------------
  // bus access, starts and ends on a falling edge
  // ------------------------------------------------
  task automatic bus_access(input logic wr, input bus_addr_t addr, input bus_word_t wdata);
    int waited;
    sys_addr_i  = addr;
    sys_wdata_i = wdata;
    sys_wen_i   = wr;
    sys_ren_i   = ~wr;
    @(negedge adc_clk);
    sys_wen_i = 1'b0;
    sys_ren_i = 1'b0;
    waited    = 1;
    while (!sys_ack_o && waited < 8) begin
      @(negedge adc_clk);
      waited++;
    end
    assert (sys_ack_o) else stop_run($sformatf("no bus ack for address 0x%0h", addr));
    check_eq("ack latency", 32'd1, 32'(waited));
    rd_data = sys_rdata_o;
    rd_err  = sys_err_o;
    if (wr) check_eq("rdata on write", 32'd0, rd_data);
  endtask

  task automatic bus_write(input bus_addr_t addr, input bus_word_t wdata, input logic exp_err);
    bus_access(1'b1, addr, wdata);
    check_eq("write err", 32'(exp_err), 32'(rd_err));
  endtask

  task automatic bus_read(input bus_addr_t addr, input logic exp_err);
    bus_access(1'b0, addr, '0);
    check_eq("read err", 32'(exp_err), 32'(rd_err));
  endtask

  task automatic read_expect(input string what, input bus_addr_t addr, input bus_word_t exp);
    bus_read(addr, 1'b0);
    check_eq(what, exp, rd_data);
  endtask

  // window of len samples from win_raw, second start at step inj
  task automatic run_window(input logic chan, input int len, input int inj);
    logic [12:0] exp_ampl;
    logic [12:0] m;
    int          exp_loc;
    exp_ampl = '0;
    exp_loc  = 0;
    for (int k = 0; k < len; k++) begin
      m = magnitude(to_twos(win_raw[k]));
      if (m >= exp_ampl) begin        // ties move to the later sample
        exp_ampl = m;
        exp_loc  = k;
      end
    end
    drive_raw(1'b0, 14'h0000);        // full scale decoys around the window
    drive_raw(1'b1, 14'h0000);
    bus_write(pd_addr(PD_LEN_OFS), bus_word_t'(len), 1'b0);
    bus_write(pd_addr(PD_CTRL_OFS), bus_word_t'({chan, 1'b1}), 1'b0);
    for (int k = 0; k < len; k++) begin
      drive_raw(chan, win_raw[k]);
      if (k == inj) bus_write(pd_addr(PD_CTRL_OFS), bus_word_t'({~chan, 1'b1}), 1'b0);
      else @(negedge adc_clk);
    end
    drive_raw(chan, 14'h0000);
    @(negedge adc_clk);
    read_expect("ctrl at L+2", pd_addr(PD_CTRL_OFS), ctrl_word(chan, 1'b1, 1'b0));
    read_expect("ctrl at L+3", pd_addr(PD_CTRL_OFS), ctrl_word(chan, 1'b0, 1'b1));
    read_expect("length", pd_addr(PD_LEN_OFS), bus_word_t'(len));
    read_expect("amplitude", pd_addr(PD_AMPL_OFS), 32'(exp_ampl));
    read_expect("location", pd_addr(PD_LOC_OFS), 32'(exp_loc));
    check_eq("led bits 6..0", 32'(exp_ampl[12:6]), 32'(led_o[6:0]));
  endtask

  // ------------------------------------------------
  // tests
  // ------------------------------------------------
  task automatic reset_test();
    test_name = "reset";
    check_eq("led", 32'd0, 32'(led_o));
    read_expect("ctrl", pd_addr(PD_CTRL_OFS), '0);
    read_expect("length", pd_addr(PD_LEN_OFS), '0);
    read_expect("amplitude", pd_addr(PD_AMPL_OFS), '0);
    read_expect("location", pd_addr(PD_LOC_OFS), '0);
  endtask

  task automatic unmapped_test();
    bus_addr_t addr;
    test_name = "unmapped";
    for (int r = 0; r < REGION_N; r++) begin
      if (r != PD_REGION) begin
        addr = (bus_addr_t'(r) << REGION_LSB) | 32'h0000_0004;
        bus_write(addr, 32'hdead_beef, 1'b1);
        bus_read(addr, 1'b1);
        check_eq("unmapped rdata", 32'd0, rd_data);
      end
    end
    bus_read(pd_addr(8'h10), 1'b1);                 // unknown offset
    bus_write(PD_BASE | 32'h0000_0104, 32'd1, 1'b1); // upper offset bits set
    bus_write(pd_addr(PD_AMPL_OFS), 32'h1fff, 1'b0); // read-only, dropped
    read_expect("ro amplitude", pd_addr(PD_AMPL_OFS), '0);
  endtask

  task automatic known_window_test();
    test_name = "known window A";
    for (int k = 0; k < 8; k++)
      win_raw[k] = KNOWN_SEQ[k];
    run_window(1'b0, 8, -1);
  endtask

  task automatic random_window_test();
    test_name = "random window B";
    for (int k = 0; k < 32; k++)
      win_raw[k] = rand_sample();
    run_window(1'b1, 32, -1);
  endtask

  task automatic start_handling_test();
    test_name = "start while busy";
    for (int k = 0; k < 16; k++)
      win_raw[k] = rand_sample();
    run_window(1'b0, 16, 5);
    test_name = "length zero";
    bus_write(pd_addr(PD_LEN_OFS), '0, 1'b0);
    bus_write(pd_addr(PD_CTRL_OFS), 32'd1, 1'b0);
    read_expect("ctrl", pd_addr(PD_CTRL_OFS), ctrl_word(1'b0, 1'b0, 1'b1));
    read_expect("amplitude", pd_addr(PD_AMPL_OFS), '0);
    read_expect("location", pd_addr(PD_LOC_OFS), '0);
  endtask

  task automatic sign_led_test(input logic chan);
    logic [13:0] raw;
    test_name = chan ? "sign led B" : "sign led A";
    bus_write(pd_addr(PD_CTRL_OFS), bus_word_t'({chan, 1'b0}), 1'b0);  // select, no start
    for (int i = 0; i < 6; i++) begin
      raw = rand_sample();
      drive_raw(chan, raw);
      drive_raw(~chan, ~raw);         // other channel has the opposite sign
      @(negedge adc_clk);
      check_eq("sign bit", 32'(to_twos(raw) >> 13), 32'(led_o[7]));
    end
  endtask

  initial begin
    reset_i     = 1'b1;
    adc_dat_a_i = '0;
    adc_dat_b_i = '0;
    sys_addr_i  = '0;
    sys_wdata_i = '0;
    sys_wen_i   = 1'b0;
    sys_ren_i   = 1'b0;
    lfsr_q      = LFSR_SEED;
    test_name   = "reset";
    repeat (RESET_CYC) @(negedge adc_clk);
    reset_i = 1'b0;
    @(negedge adc_clk);
    reset_test();
    unmapped_test();
    known_window_test();
    random_window_test();
    start_handling_test();
    sign_led_test(1'b0);
    sign_led_test(1'b1);
    $display("Everything OK");
    $finish;
  end

endmodule

/* src.f */
rp_bus_pkg.sv
rp_adc_pkg.sv
sys_bus_if.sv
sys_bus_decoder.sv
adc_frontend.sv
pd_ctrl_fsm.sv
pd_window_counter.sv
pd_peak_tracker.sv
pd_regs.sv
rp_top.sv
tb_rp_top.sv

/* Makefile */
VERILATOR := verilator
VFLAGS    := --binary --timing --assert -j 0
TOP       := tb_rp_top
FILELIST  := src.f
OBJ_DIR   := obj_dir
PASS_MSG  := Everything OK

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) --lint-only --timing --assert --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
